//--- Makefile
# Verilator simulation of the rx digital core

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_rx_digital_core -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
rtl/phy_pkg.sv
rtl/adc_retimer.sv
rtl/cdr_loop.sv
rtl/sample_dump.sv
rtl/dbg_regs.sv
rtl/rx_digital_core.sv
verification/tb_clock_gen.sv
verification/rx_digital_core_assertions.sv
verification/tb_rx_digital_core.sv

//--- rtl/adc_retimer.sv
`timescale 1ns/1ps
`default_nettype none

module adc_retimer (
	input  wire logic clk_adc_i,
	input  wire logic rst_n_i,

	// raw lanes from the interleaved adc
	input  wire phy_pkg::adc_mag_t [phy_pkg::NTI-1:0] adc_mag_i,
	input  wire logic [phy_pkg::NTI-1:0] adc_sign_i,

	output phy_pkg::lane_smp_t [phy_pkg::NTI-1:0] smp_o,
	output logic smp_vld_o
);

	phy_pkg::lane_smp_t [phy_pkg::NTI-1:0] smp_d;

	// sign-magnitude to two's complement, sign 1 is negative
	always_comb begin
		for (int k = 0; k < phy_pkg::NTI; k++) begin
			if (adc_sign_i[k]) begin
				smp_d[k] = -$signed({1'b0, adc_mag_i[k]});
			end else begin
				smp_d[k] = $signed({1'b0, adc_mag_i[k]});
			end
		end
	end

	// lane payload
	always_ff @(posedge clk_adc_i) begin
		smp_o <= smp_d;
	end

	// valid comes up on the first edge out of reset
	always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			smp_vld_o <= 1'b0;
		end else begin
			smp_vld_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cdr_loop.sv
`timescale 1ns/1ps
`default_nettype none

module cdr_loop (
	input  wire logic clk_adc_i,
	input  wire logic rst_n_i,

	input  wire phy_pkg::lane_smp_t [phy_pkg::NTI-1:0] smp_i,
	input  wire logic smp_vld_i,

	// loop control from the register block
	input  wire logic cdr_en_i,
	input  wire logic pi_ext_en_i,
	input  wire phy_pkg::gain_t gain_i,
	input  wire phy_pkg::pi_code_t pi_ext_i,

	output phy_pkg::pi_code_t pi_ctl_o
);

	phy_pkg::lane_smp_t prev_last_q;  // lane NTI-1 of the last valid cycle
	phy_pkg::lane_smp_t [phy_pkg::NTI:0] win;
	phy_pkg::acc_t vote_sum;
	phy_pkg::acc_t acc_q;

	// mueller-muller vote: sgn(prv)*cur - sgn(cur)*prv, reduced to -1/0/+1
	function automatic logic [1:0] mm_vote(
		input phy_pkg::lane_smp_t prv,
		input phy_pkg::lane_smp_t cur
	);
		logic signed [phy_pkg::NADC+2:0] ta;
		logic signed [phy_pkg::NADC+2:0] tb;
		logic signed [phy_pkg::NADC+2:0] diff;
		ta = {{2{cur[phy_pkg::NADC]}}, cur};
		tb = {{2{prv[phy_pkg::NADC]}}, prv};
		if (prv[phy_pkg::NADC]) ta = -ta;  // sgn(prv) = -1
		if (cur[phy_pkg::NADC]) tb = -tb;
		diff = ta - tb;
		if (diff == '0) begin
			mm_vote = 2'b00;
		end else if (diff[phy_pkg::NADC+2]) begin
			mm_vote = 2'b11;
		end else begin
			mm_vote = 2'b01;
		end
	endfunction

	// slot 0 is the carried sample, slots 1..NTI are this cycle's lanes
	assign win = {smp_i, prev_last_q};

	always_comb begin
		vote_sum = '0;
		for (int k = 0; k < phy_pkg::NTI; k++) begin
			logic [1:0] v;
			v = mm_vote(win[k], win[k+1]);
			vote_sum = vote_sum + {{(phy_pkg::ACC_W-2){v[1]}}, v};
		end
	end

	always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q       <= '0;
			prev_last_q <= '0;
		end else begin
			if (pi_ext_en_i) begin
				// manual override loads the code, lower bits cleared
				acc_q <= {pi_ext_i, {(phy_pkg::ACC_W-phy_pkg::NPI){1'b0}}};
			end else if (cdr_en_i && smp_vld_i) begin
				acc_q <= acc_q + (vote_sum << gain_i);  // wraps
			end
			if (smp_vld_i) prev_last_q <= smp_i[phy_pkg::NTI-1];
		end
	end

	assign pi_ctl_o = acc_q[phy_pkg::ACC_W-1 -: phy_pkg::NPI];

endmodule

`default_nettype wire

//--- rtl/dbg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_regs (
	input  wire logic clk_adc_i,
	input  wire logic rst_n_i,

	// wishbone classic slave
	input  wire logic wb_cyc_i,
	input  wire logic wb_stb_i,
	input  wire logic wb_we_i,
	input  wire phy_pkg::wb_addr_t wb_adr_i,
	input  wire phy_pkg::wb_data_t wb_dat_i,
	output phy_pkg::wb_data_t wb_dat_o,
	output logic wb_ack_o,

	// status in
	input  wire phy_pkg::pi_code_t pi_ctl_i,
	input  wire logic dump_done_i,
	input  wire phy_pkg::lane_smp_t dump_rd_data_i,

	// control out
	output logic cdr_en_o,
	output logic pi_ext_en_o,
	output phy_pkg::gain_t gain_o,
	output phy_pkg::pi_code_t pi_ext_o,
	output phy_pkg::dump_idx_t dump_rd_idx_o
);

	logic [1:0] ctrl_q;  // bit 0 cdr_en, bit 1 pi_ext_en
	logic access;
	phy_pkg::wb_data_t rd_mux;

	// one access per ack, never back to back
	assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

	always_comb begin
		case (wb_adr_i)
			phy_pkg::REG_CTRL:      rd_mux = phy_pkg::wb_data_t'(ctrl_q);
			phy_pkg::REG_GAIN:      rd_mux = phy_pkg::wb_data_t'(gain_o);
			phy_pkg::REG_PI_EXT:    rd_mux = phy_pkg::wb_data_t'(pi_ext_o);
			phy_pkg::REG_PI_STAT:   rd_mux = phy_pkg::wb_data_t'(pi_ctl_i);  // live code
			phy_pkg::REG_DUMP_STAT: rd_mux = phy_pkg::wb_data_t'(dump_done_i);
			phy_pkg::REG_DUMP_IDX:  rd_mux = phy_pkg::wb_data_t'(dump_rd_idx_o);
			phy_pkg::REG_DUMP_DATA: begin
				// sign extended, reads zero until a capture has finished
				if (dump_done_i) begin
					rd_mux = {{($bits(phy_pkg::wb_data_t)-phy_pkg::NADC-1)
						{dump_rd_data_i[phy_pkg::NADC]}}, dump_rd_data_i};
				end else begin
					rd_mux = '0;
				end
			end
			default:                rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_ack_o      <= 1'b0;
			wb_dat_o      <= '0;
			ctrl_q        <= '0;
			gain_o        <= '0;
			pi_ext_o      <= '0;
			dump_rd_idx_o <= '0;
		end else begin
			wb_ack_o <= access;
			if (access && wb_we_i) begin
				case (wb_adr_i)
					phy_pkg::REG_CTRL:     ctrl_q <= wb_dat_i[1:0];
					phy_pkg::REG_GAIN:     gain_o <= wb_dat_i[$bits(phy_pkg::gain_t)-1:0];
					phy_pkg::REG_PI_EXT:   pi_ext_o <= wb_dat_i[phy_pkg::NPI-1:0];
					phy_pkg::REG_DUMP_IDX: begin
						dump_rd_idx_o <= wb_dat_i[$bits(phy_pkg::dump_idx_t)-1:0];
					end
					default: ;  // read-only or unmapped
				endcase
			end else if (access) begin
				wb_dat_o <= rd_mux;  // held while ack is high
			end
		end
	end

	assign cdr_en_o    = ctrl_q[0];
	assign pi_ext_en_o = ctrl_q[1];

endmodule

`default_nettype wire

//--- rtl/phy_pkg.sv
`default_nettype none

package phy_pkg;

	// front end geometry
	localparam int NTI  = 4;  // interleaved adc lanes
	localparam int NADC = 8;  // adc magnitude bits
	localparam int NPI  = 9;  // pi control code bits

	// loop integrator, pi code is its top NPI bits
	localparam int ACC_W = 16;

	// clk_adc cycles per capture
	localparam int DUMP_DEPTH = 16;

	typedef logic [NADC-1:0] adc_mag_t;
	typedef logic signed [NADC:0] lane_smp_t;  // two's complement lane sample
	typedef logic [NPI-1:0] pi_code_t;
	typedef logic [ACC_W-1:0] acc_t;

	// debug bus
	typedef logic [3:0] wb_addr_t;
	typedef logic [15:0] wb_data_t;

	// entry * NTI + lane
	typedef logic [5:0] dump_idx_t;

	typedef logic [2:0] gain_t;  // left shift of the vote sum

	// register map, word addresses
	localparam wb_addr_t REG_CTRL      = 4'd0;
	localparam wb_addr_t REG_GAIN      = 4'd1;
	localparam wb_addr_t REG_PI_EXT    = 4'd2;
	localparam wb_addr_t REG_PI_STAT   = 4'd3;
	localparam wb_addr_t REG_DUMP_STAT = 4'd4;
	localparam wb_addr_t REG_DUMP_IDX  = 4'd5;
	localparam wb_addr_t REG_DUMP_DATA = 4'd6;

endpackage

`default_nettype wire

//--- rtl/rx_digital_core.sv
`timescale 1ns/1ps
`default_nettype none

module rx_digital_core (
	input  wire logic clk_adc_i,
	input  wire logic rst_n_i,

	// adc lanes
	input  wire phy_pkg::adc_mag_t [phy_pkg::NTI-1:0] adc_mag_i,
	input  wire logic [phy_pkg::NTI-1:0] adc_sign_i,

	input  wire logic ext_dump_start_i,

	// to the analog core
	output wire phy_pkg::pi_code_t pi_ctl_o,

	// debug bus
	input  wire logic wb_cyc_i,
	input  wire logic wb_stb_i,
	input  wire logic wb_we_i,
	input  wire phy_pkg::wb_addr_t wb_adr_i,
	input  wire phy_pkg::wb_data_t wb_dat_i,
	output wire phy_pkg::wb_data_t wb_dat_o,
	output wire logic wb_ack_o
);

	phy_pkg::lane_smp_t [phy_pkg::NTI-1:0] smp_q;
	logic smp_vld;
	logic cdr_en;
	logic pi_ext_en;
	phy_pkg::gain_t gain;
	phy_pkg::pi_code_t pi_ext;
	phy_pkg::pi_code_t pi_ctl;
	phy_pkg::dump_idx_t dump_rd_idx;
	logic dump_done;
	phy_pkg::lane_smp_t dump_rd_data;

	adc_retimer adc_retimer_inst (
		.clk_adc_i (clk_adc_i),
		.rst_n_i   (rst_n_i),
		.adc_mag_i (adc_mag_i),
		.adc_sign_i(adc_sign_i),
		.smp_o     (smp_q),
		.smp_vld_o (smp_vld)
	);

	cdr_loop cdr_loop_inst (
		.clk_adc_i  (clk_adc_i),
		.rst_n_i    (rst_n_i),
		.smp_i      (smp_q),
		.smp_vld_i  (smp_vld),
		.cdr_en_i   (cdr_en),
		.pi_ext_en_i(pi_ext_en),
		.gain_i     (gain),
		.pi_ext_i   (pi_ext),
		.pi_ctl_o   (pi_ctl)  // shared pi code
	);

	assign pi_ctl_o = pi_ctl;

	sample_dump sample_dump_inst (
		.clk_adc_i       (clk_adc_i),
		.rst_n_i         (rst_n_i),
		.ext_dump_start_i(ext_dump_start_i),
		.smp_i           (smp_q),
		.smp_vld_i       (smp_vld),
		.rd_idx_i        (dump_rd_idx),
		.dump_done_o     (dump_done),
		.rd_data_o       (dump_rd_data)
	);

	dbg_regs dbg_regs_inst (
		.clk_adc_i     (clk_adc_i),
		.rst_n_i       (rst_n_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.pi_ctl_i      (pi_ctl),
		.dump_done_i   (dump_done),
		.dump_rd_data_i(dump_rd_data),
		.cdr_en_o      (cdr_en),
		.pi_ext_en_o   (pi_ext_en),
		.gain_o        (gain),
		.pi_ext_o      (pi_ext),
		.dump_rd_idx_o (dump_rd_idx)
	);

endmodule

`default_nettype wire

//--- rtl/sample_dump.sv
`timescale 1ns/1ps
`default_nettype none

module sample_dump (
	input  wire logic clk_adc_i,
	input  wire logic rst_n_i,

	input  wire logic ext_dump_start_i,  // async pin
	input  wire phy_pkg::lane_smp_t [phy_pkg::NTI-1:0] smp_i,
	input  wire logic smp_vld_i,
	input  wire phy_pkg::dump_idx_t rd_idx_i,

	output logic dump_done_o,
	output phy_pkg::lane_smp_t rd_data_o
);

	typedef enum logic [1:0] {
		IDLE,
		CAPTURE,
		DONE
	} dump_state_e;

	typedef logic [$clog2(phy_pkg::DUMP_DEPTH)-1:0] entry_t;

	dump_state_e state_q;
	logic [1:0] sync_q;
	logic start_d_q;
	logic start_rise;
	entry_t wr_ptr_q;
	logic wr_en;
	entry_t rd_entry;
	logic [$clog2(phy_pkg::NTI)-1:0] rd_lane;

	phy_pkg::lane_smp_t [phy_pkg::NTI-1:0] mem_q [phy_pkg::DUMP_DEPTH];

	assign start_rise = sync_q[1] & ~start_d_q;  // edge seen after 2nd flop
	assign wr_en      = (state_q == CAPTURE) && smp_vld_i;

	// index / NTI picks the entry, the remainder picks the lane
	assign {rd_entry, rd_lane} = rd_idx_i;

	always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q    <= '0;
			start_d_q <= 1'b0;
			state_q   <= IDLE;
			wr_ptr_q  <= '0;
		end else begin
			sync_q    <= {sync_q[0], ext_dump_start_i};
			start_d_q <= sync_q[1];
			if (start_rise) begin
				// arm or re-arm from any state
				state_q  <= CAPTURE;
				wr_ptr_q <= '0;
			end else if (wr_en) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
				if (wr_ptr_q == entry_t'(phy_pkg::DUMP_DEPTH - 1)) state_q <= DONE;
			end
		end
	end

	assign dump_done_o = (state_q == DONE);

	// capture memory with registered read port
	always_ff @(posedge clk_adc_i) begin
		if (wr_en) mem_q[wr_ptr_q] <= smp_i;
		rd_data_o <= mem_q[rd_entry][rd_lane];
	end

endmodule

`default_nettype wire

//--- verification/rx_digital_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rx_digital_core_assertions (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_ack_i,
	input wire phy_pkg::wb_data_t wb_dat_i,
	input wire phy_pkg::pi_code_t pi_ctl_i,
	input wire logic cdr_en_i,
	input wire logic pi_ext_en_i
);

	// ack lasts a single cycle
	ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o held for more than one cycle");

	ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o high without cyc and stb");

	// loop frozen when both control bits are clear
	pi_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(!cdr_en_i && !pi_ext_en_i) |=> $stable(pi_ctl_i))
		else $error("pi_ctl_o moved with the loop disabled");

	no_x_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!$isunknown({pi_ctl_i, wb_ack_i, wb_dat_i}))
		else $error("output is unknown after reset");

endmodule

bind rx_digital_core rx_digital_core_assertions rx_digital_core_assertions_inst (
	.clk_i      (clk_adc_i),
	.rst_n_i    (rst_n_i),
	.wb_cyc_i   (wb_cyc_i),
	.wb_stb_i   (wb_stb_i),
	.wb_ack_i   (wb_ack_o),
	.wb_dat_i   (wb_dat_o),
	.pi_ctl_i   (pi_ctl_o),
	.cdr_en_i   (cdr_en),
	.pi_ext_en_i(pi_ext_en)
);

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;  // 100 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (10) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

//--- verification/tb_rx_digital_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rx_digital_core;

	localparam int NTI = phy_pkg::NTI;
	localparam int ACC_CYC = 4;  // cycles per bus access including the idle one
	localparam int RUN_CYCLES = 10 + 16 * ACC_CYC + 34 * ACC_CYC + 5 * (2 * ACC_CYC + 2)
		+ 8 * (4 * ACC_CYC + 200) + 2 * (40 * ACC_CYC + 2 * 64 * ACC_CYC);
	localparam int CYCLE_LIMIT = RUN_CYCLES * 3 / 2;
	localparam int ACK_WAIT = 16;
	localparam int POLL_LIMIT = 40;

	logic clk;
	logic rst_n;
	phy_pkg::adc_mag_t [NTI-1:0] adc_mag;
	logic [NTI-1:0] adc_sign;
	logic ext_dump_start;
	phy_pkg::pi_code_t pi_ctl;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	phy_pkg::wb_addr_t wb_adr;
	phy_pkg::wb_data_t wb_dat_w;
	phy_pkg::wb_data_t wb_dat_r;
	logic wb_ack;

	// reference model state
	phy_pkg::lane_smp_t [NTI-1:0] smp_m;
	phy_pkg::lane_smp_t prev_m;
	logic vld_m;
	phy_pkg::acc_t acc_m;
	logic ack_m;
	logic [1:0] ctrl_m;
	phy_pkg::gain_t gain_m;
	phy_pkg::pi_code_t piext_m;
	phy_pkg::lane_smp_t [NTI-1:0] hist[$];
	int wraps;  // integrator wrap-arounds seen by the model

	int errors;
	int checks;
	int cycles;
	logic drive_adc;

	tb_clock_gen tb_clock_gen_inst (
		.clk_o  (clk),
		.rst_n_o(rst_n)
	);

	rx_digital_core rx_digital_core_inst (
		.clk_adc_i       (clk),
		.rst_n_i         (rst_n),
		.adc_mag_i       (adc_mag),
		.adc_sign_i      (adc_sign),
		.ext_dump_start_i(ext_dump_start),
		.pi_ctl_o        (pi_ctl),
		.wb_cyc_i        (wb_cyc),
		.wb_stb_i        (wb_stb),
		.wb_we_i         (wb_we),
		.wb_adr_i        (wb_adr),
		.wb_dat_i        (wb_dat_w),
		.wb_dat_o        (wb_dat_r),
		.wb_ack_o        (wb_ack)
	);

	function automatic phy_pkg::lane_smp_t [NTI-1:0] lanes_from_adc(
		input phy_pkg::adc_mag_t [NTI-1:0] mag,
		input logic [NTI-1:0] sgn
	);
		phy_pkg::lane_smp_t [NTI-1:0] res;
		int v;
		for (int k = 0; k < NTI; k++) begin
			v = int'(mag[k]);
			if (sgn[k]) v = -v;  // sign 1 is negative
			res[k] = phy_pkg::lane_smp_t'(v);
		end
		return res;
	endfunction

	// bang-bang mueller-muller decision
	function automatic int vote_of(input int prv, input int cur);
		int sp;
		int sc;
		int d;
		sp = (prv >= 0) ? 1 : -1;
		sc = (cur >= 0) ? 1 : -1;
		d = sp * cur - sc * prv;
		if (d > 0) return 1;
		if (d < 0) return -1;
		return 0;
	endfunction

	// random adc lanes on every cycle
	always @(posedge clk) begin
		if (drive_adc) begin
			for (int k = 0; k < NTI; k++) begin
				adc_mag[k] <= phy_pkg::adc_mag_t'($urandom);
			end
			adc_sign <= NTI'($urandom);
		end
	end

	always @(posedge clk or negedge rst_n) begin
		int vsum;
		int prv;
		int nxt;
		if (!rst_n) begin
			vld_m   <= 1'b0;
			acc_m   <= '0;
			prev_m  <= '0;
			ack_m   <= 1'b0;
			ctrl_m  <= '0;
			gain_m  <= '0;
			piext_m <= '0;
		end else begin
			vsum = 0;
			prv = int'($signed(prev_m));
			for (int k = 0; k < NTI; k++) begin
				vsum += vote_of(prv, int'($signed(smp_m[k])));
				prv = int'($signed(smp_m[k]));
			end
			if (ctrl_m[1]) begin
				acc_m <= phy_pkg::acc_t'({piext_m, {(phy_pkg::ACC_W - phy_pkg::NPI){1'b0}}});
			end else if (ctrl_m[0] && vld_m) begin
				nxt = int'(acc_m) + (vsum << gain_m);
				if (nxt < 0 || nxt >= (1 << phy_pkg::ACC_W)) wraps++;
				acc_m <= phy_pkg::acc_t'(nxt);  // mod 2^16
			end
			if (vld_m) prev_m <= smp_m[NTI-1];
			smp_m <= lanes_from_adc(adc_mag, adc_sign);
			hist.push_back(lanes_from_adc(adc_mag, adc_sign));
			vld_m <= 1'b1;
			// register writes land on the same edge as in the slave
			ack_m <= wb_cyc && wb_stb && !ack_m;
			if (wb_cyc && wb_stb && !ack_m && wb_we) begin
				case (wb_adr)
					phy_pkg::REG_CTRL:   ctrl_m <= wb_dat_w[1:0];
					phy_pkg::REG_GAIN:   gain_m <= wb_dat_w[2:0];
					phy_pkg::REG_PI_EXT: piext_m <= wb_dat_w[phy_pkg::NPI-1:0];
					default: ;
				endcase
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run exceeded %0d cycles without finishing", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_access(input phy_pkg::wb_addr_t adr, input logic we,
		input phy_pkg::wb_data_t wdat, output phy_pkg::wb_data_t rdat);
		int waited;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < ACK_WAIT);
		if (!wb_ack) begin
			$display("no Wishbone ack within %0d cycles at address %0d", ACK_WAIT, adr);
			errors++;
		end
		rdat = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic write_reg(input phy_pkg::wb_addr_t adr, input phy_pkg::wb_data_t d);
		phy_pkg::wb_data_t unused;
		bus_access(adr, 1'b1, d, unused);
	endtask

	task automatic read_reg(input phy_pkg::wb_addr_t adr, output phy_pkg::wb_data_t d);
		bus_access(adr, 1'b0, '0, d);
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	// pulse the start pin, wait for done, locate the capture in the history
	task automatic capture_dump(output int start);
		phy_pkg::wb_data_t d;
		phy_pkg::lane_smp_t [NTI-1:0] cap[phy_pkg::DUMP_DEPTH];
		int polls;
		bit match;
		@(posedge clk);
		ext_dump_start <= 1'b1;
		repeat (4) @(posedge clk);
		ext_dump_start <= 1'b0;
		read_reg(phy_pkg::REG_DUMP_STAT, d);
		check_value("dump_done", 32'(d), 32'h0);  // cleared by the new edge
		polls = 0;
		do begin
			read_reg(phy_pkg::REG_DUMP_STAT, d);
			polls++;
		end while (d[0] !== 1'b1 && polls < POLL_LIMIT);
		start = -1;
		if (d[0] !== 1'b1) begin
			$display("dump_done never rose after the start pulse");
			errors++;
			return;
		end
		for (int i = 0; i < phy_pkg::DUMP_DEPTH * NTI; i++) begin
			write_reg(phy_pkg::REG_DUMP_IDX, phy_pkg::wb_data_t'(i));
			read_reg(phy_pkg::REG_DUMP_DATA, d);
			check_value("wb_dat_o", 32'(d[15:9]), {25'd0, {7{d[8]}}});
			cap[i / NTI][i % NTI] = phy_pkg::lane_smp_t'(d[8:0]);
		end
		for (int j = 0; j + phy_pkg::DUMP_DEPTH <= hist.size(); j++) begin
			match = 1'b1;
			for (int e = 0; e < phy_pkg::DUMP_DEPTH; e++) begin
				if (hist[j + e] !== cap[e]) match = 1'b0;
			end
			if (match) begin
				start = j;
				break;
			end
		end
		if (start < 0) begin
			$display("dump contents match no window of the sample history");
			errors++;
		end
	endtask

	initial begin
		phy_pkg::wb_data_t d;
		phy_pkg::wb_data_t w;
		phy_pkg::pi_code_t code;
		int eb;
		int wraps_seen;
		int first_start;
		int second_start;
		phy_pkg::wb_data_t masks[4];
		phy_pkg::wb_addr_t addrs[4];
		void'($urandom(32'h7491_80af));
		errors = 0;
		checks = 0;
		cycles = 0;
		wraps = 0;
		drive_adc = 1'b0;
		adc_mag = '0;
		adc_sign = '0;
		ext_dump_start = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		addrs = '{phy_pkg::REG_CTRL, phy_pkg::REG_GAIN, phy_pkg::REG_PI_EXT,
			phy_pkg::REG_DUMP_IDX};
		masks = '{16'h0003, 16'h0007, 16'h01ff, 16'h003f};
		wait (rst_n === 1'b1);
		drive_adc = 1'b1;

		eb = errors;
		@(negedge clk);
		check_value("pi_ctl_o", 32'(pi_ctl), 32'h0);
		check_value("wb_ack_o", 32'(wb_ack), 32'h0);
		for (int a = 0; a < 16; a++) begin
			read_reg(phy_pkg::wb_addr_t'(a), d);
			check_value("wb_dat_o", 32'(d), 32'h0);
		end
		report_test("reset state", eb);

		eb = errors;
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 4; i++) begin
				w = phy_pkg::wb_data_t'($urandom);
				write_reg(addrs[i], w);
				read_reg(addrs[i], d);
				check_value("wb_dat_o", 32'(d), 32'(w & masks[i]));
			end
		end
		for (int a = 7; a < 16; a++) begin
			write_reg(phy_pkg::wb_addr_t'(a), phy_pkg::wb_data_t'($urandom));
			read_reg(phy_pkg::wb_addr_t'(a), d);
			check_value("wb_dat_o", 32'(d), 32'h0);
		end
		write_reg(phy_pkg::REG_CTRL, 16'h0000);
		report_test("register access", eb);

		eb = errors;
		write_reg(phy_pkg::REG_CTRL, 16'h0002);
		for (int i = 0; i < 5; i++) begin
			code = phy_pkg::pi_code_t'($urandom);
			write_reg(phy_pkg::REG_PI_EXT, phy_pkg::wb_data_t'(code));
			repeat (2) @(negedge clk);
			check_value("pi_ctl_o", 32'(pi_ctl), 32'(code));
			read_reg(phy_pkg::REG_PI_STAT, d);
			check_value("wb_dat_o", 32'(d), 32'(code));
		end
		report_test("manual override", eb);

		eb = errors;
		wraps_seen = wraps;
		for (int g = 0; g < 8; g++) begin
			// even gains start at code zero so the walk wraps below zero
			if (g % 2 == 0) begin
				code = '0;
			end else begin
				code = phy_pkg::pi_code_t'($urandom);
			end
			write_reg(phy_pkg::REG_CTRL, 16'h0002);
			write_reg(phy_pkg::REG_PI_EXT, phy_pkg::wb_data_t'(code));
			write_reg(phy_pkg::REG_GAIN, phy_pkg::wb_data_t'(g));
			write_reg(phy_pkg::REG_CTRL, 16'h0001);
			repeat (200) begin
				@(negedge clk);
				check_value("pi_ctl_o", 32'(pi_ctl),
					32'(acc_m[phy_pkg::ACC_W-1 -: phy_pkg::NPI]));
			end
		end
		write_reg(phy_pkg::REG_CTRL, 16'h0000);
		if (wraps == wraps_seen) begin
			$display("loop integrator never wrapped around during tracking");
			errors++;
		end
		report_test("loop tracking", eb);

		eb = errors;
		capture_dump(first_start);
		report_test("sample dump", eb);

		eb = errors;
		capture_dump(second_start);
		if (first_start >= 0 && second_start <= first_start) begin
			$display("second capture is not later than the first one");
			errors++;
		end
		report_test("dump re-arm", eb);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
